/* rtl/l1i_pkg.sv */
package l1i_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_BITS      = WORD_BITS * WORDS_PER_LINE;
    localparam int SETS           = 16;
    localparam int WAYS           = 2;
    // RAM read cycles between rd_en and lookup
    localparam int READ_LATENCY   = 1;
    localparam int OFFSET_BITS    = $clog2(WORDS_PER_LINE);
    localparam int INDEX_BITS     = $clog2(SETS);
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS - 2;

    typedef logic [ADDR_BITS-1:0]     addr_t;
    typedef logic [WORD_BITS-1:0]     word_t;
    typedef logic [LINE_BITS-1:0]     line_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [OFFSET_BITS-1:0]   offset_t;
    typedef logic [$clog2(WAYS)-1:0]  way_t;

    typedef struct packed {
        logic   hit;
        way_t   hit_way;
        way_t   victim;
        line_t  line;
    } lookup_t;

    typedef struct packed {
        way_t   way;
        index_t index;
        tag_t   tag;
        line_t  line;
    } line_write_t;

    typedef struct packed {
        addr_t                    addr;
        word_t                    wdata;
        logic [WORD_BITS/8-1:0]   wstrb;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        RESPOND,
        REFILL,
        FILL
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[ADDR_BITS-1:ADDR_BITS-TAG_BITS];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[OFFSET_BITS+2 +: INDEX_BITS];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[2 +: OFFSET_BITS];
    endfunction

    // Byte address of word 0 of the line
    function automatic addr_t line_base(addr_t addr);
        return {addr[ADDR_BITS-1:OFFSET_BITS+2], {(OFFSET_BITS+2){1'b0}}};
    endfunction

    function automatic word_t line_word(line_t line, offset_t off);
        return line[off*WORD_BITS +: WORD_BITS];
    endfunction

endpackage

/* rtl/l1i_controller.sv */
`timescale 1ns/1ns

module l1i_controller (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    fetch_valid_i,
    input  l1i_pkg::addr_t          fetch_addr_i,
    output logic                    fetch_ready_o,
    output logic                    resp_valid_o,
    output l1i_pkg::word_t          resp_word_o,
    input  logic                    resp_ready_i,
    output logic                    rd_en_o,
    output l1i_pkg::index_t         rd_index_o,
    output l1i_pkg::tag_t           rd_tag_o,
    input  l1i_pkg::lookup_t        lookup_i,
    input  logic                    lookup_valid_i,
    output logic                    wr_en_o,
    output l1i_pkg::line_write_t    line_write_o,
    output logic                    refill_valid_o,
    output l1i_pkg::addr_t          refill_addr_o,
    input  logic                    refill_ready_i,
    input  logic                    fill_valid_i,
    input  l1i_pkg::line_t          fill_line_i
);

    l1i_pkg::ctrl_state_t   state_q;
    logic                   rd_en_q;
    logic                   refill_valid_q;
    l1i_pkg::addr_t         addr_q;
    l1i_pkg::way_t          victim_q;
    l1i_pkg::line_t         fill_line_q;
    l1i_pkg::word_t         resp_word_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q        <= l1i_pkg::IDLE;
            rd_en_q        <= 1'b0;
            refill_valid_q <= 1'b0;
        end else begin
            rd_en_q <= 1'b0;
            case (state_q)
                l1i_pkg::IDLE: begin
                    if (fetch_valid_i) begin
                        rd_en_q <= 1'b1;
                        state_q <= l1i_pkg::LOOKUP;
                    end
                end
                l1i_pkg::LOOKUP: begin
                    if (lookup_valid_i) begin
                        if (lookup_i.hit) begin
                            state_q <= l1i_pkg::RESPOND;
                        end else begin
                            refill_valid_q <= 1'b1;
                            state_q        <= l1i_pkg::REFILL;
                        end
                    end
                end
                l1i_pkg::REFILL: begin
                    if (refill_ready_i) begin
                        refill_valid_q <= 1'b0;
                    end
                    if (fill_valid_i) begin
                        state_q <= l1i_pkg::FILL;
                    end
                end
                l1i_pkg::FILL: begin
                    state_q <= l1i_pkg::RESPOND;
                end
                l1i_pkg::RESPOND: begin
                    if (resp_ready_i) begin
                        state_q <= l1i_pkg::IDLE;
                    end
                end
                default: begin
                    state_q <= l1i_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == l1i_pkg::IDLE && fetch_valid_i) begin
            addr_q <= fetch_addr_i;
        end
        if (state_q == l1i_pkg::LOOKUP && lookup_valid_i) begin
            victim_q    <= lookup_i.victim;
            resp_word_q <= l1i_pkg::line_word(lookup_i.line, l1i_pkg::addr_offset(addr_q));
        end
        if (state_q == l1i_pkg::REFILL && fill_valid_i) begin
            fill_line_q <= fill_line_i;
        end
        // Answer straight from the refilled line without a second lookup
        if (state_q == l1i_pkg::FILL) begin
            resp_word_q <= l1i_pkg::line_word(fill_line_q, l1i_pkg::addr_offset(addr_q));
        end
    end

    assign fetch_ready_o = (state_q == l1i_pkg::IDLE);
    assign resp_valid_o  = (state_q == l1i_pkg::RESPOND);
    assign resp_word_o   = resp_word_q;

    assign rd_en_o    = rd_en_q;
    assign rd_index_o = l1i_pkg::addr_index(addr_q);
    assign rd_tag_o   = l1i_pkg::addr_tag(addr_q);

    assign wr_en_o            = (state_q == l1i_pkg::FILL);
    assign line_write_o.way   = victim_q;
    assign line_write_o.index = l1i_pkg::addr_index(addr_q);
    assign line_write_o.tag   = l1i_pkg::addr_tag(addr_q);
    assign line_write_o.line  = fill_line_q;

    assign refill_valid_o = refill_valid_q;
    assign refill_addr_o  = l1i_pkg::line_base(addr_q);

endmodule

/* rtl/l1i_way_store.sv */
`timescale 1ns/1ns

module l1i_way_store (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    rd_en_i,
    input  l1i_pkg::index_t         rd_index_i,
    input  l1i_pkg::tag_t           rd_tag_i,
    output l1i_pkg::lookup_t        lookup_o,
    output logic                    lookup_valid_o,
    input  logic                    wr_en_i,
    input  l1i_pkg::line_write_t    line_write_i
);

    l1i_pkg::tag_t              tag_ram  [l1i_pkg::WAYS][l1i_pkg::SETS];
    l1i_pkg::line_t             data_ram [l1i_pkg::WAYS][l1i_pkg::SETS];
    l1i_pkg::tag_t              tag_rd   [l1i_pkg::WAYS];
    l1i_pkg::line_t             data_rd  [l1i_pkg::WAYS];
    logic [l1i_pkg::WAYS-1:0]   valid_q  [l1i_pkg::SETS];
    l1i_pkg::way_t              victim_q [l1i_pkg::SETS];
    logic [l1i_pkg::READ_LATENCY-1:0] rd_pipe_q;
    l1i_pkg::index_t            index_q;
    l1i_pkg::tag_t              tag_q;

    // One synchronous tag RAM and one data RAM per way
    always_ff @(posedge clk) begin
        for (int w = 0; w < l1i_pkg::WAYS; w++) begin
            if (wr_en_i && line_write_i.way == l1i_pkg::way_t'(w)) begin
                tag_ram[w][line_write_i.index]  <= line_write_i.tag;
                data_ram[w][line_write_i.index] <= line_write_i.line;
            end
            if (rd_en_i) begin
                tag_rd[w]  <= tag_ram[w][rd_index_i];
                data_rd[w] <= data_ram[w][rd_index_i];
            end
        end
        if (rd_en_i) begin
            index_q <= rd_index_i;
            tag_q   <= rd_tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_pipe_q <= '0;
            for (int s = 0; s < l1i_pkg::SETS; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= '0;
            end
        end else begin
            rd_pipe_q[0] <= rd_en_i;
            for (int i = 1; i < l1i_pkg::READ_LATENCY; i++) begin
                rd_pipe_q[i] <= rd_pipe_q[i-1];
            end
            if (wr_en_i) begin
                valid_q[line_write_i.index][line_write_i.way] <= 1'b1;
                victim_q[line_write_i.index] <= victim_q[line_write_i.index] + 1'b1;
            end
        end
    end

    assign lookup_valid_o = rd_pipe_q[l1i_pkg::READ_LATENCY-1];

    always_comb begin
        lookup_o        = '0;
        // First invalid way wins over the round-robin bit
        lookup_o.victim = victim_q[index_q];
        for (int w = l1i_pkg::WAYS - 1; w >= 0; w--) begin
            if (!valid_q[index_q][w]) begin
                lookup_o.victim = l1i_pkg::way_t'(w);
            end
        end
        for (int w = 0; w < l1i_pkg::WAYS; w++) begin
            if (valid_q[index_q][w] && tag_rd[w] == tag_q) begin
                lookup_o.hit     = 1'b1;
                lookup_o.hit_way = l1i_pkg::way_t'(w);
            end
        end
        lookup_o.line = data_rd[lookup_o.hit_way];
    end

endmodule

/* rtl/mem_bus_bridge.sv */
`timescale 1ns/1ns

module mem_bus_bridge (
    input  logic                clk,
    input  logic                resetn,
    input  logic                refill_valid_i,
    input  l1i_pkg::addr_t      refill_addr_i,
    output logic                refill_ready_o,
    output logic                fill_valid_o,
    output l1i_pkg::line_t      fill_line_o,
    output logic                iomem_valid_o,
    output l1i_pkg::mem_req_t   iomem_req_o,
    input  logic                iomem_ready_i,
    input  l1i_pkg::word_t      iomem_rdata_i
);

    logic               busy_q;
    logic               req_valid_q;
    logic               fill_valid_q;
    l1i_pkg::offset_t   word_cnt_q;
    l1i_pkg::addr_t     base_q;
    l1i_pkg::line_t     line_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q       <= 1'b0;
            req_valid_q  <= 1'b0;
            fill_valid_q <= 1'b0;
            word_cnt_q   <= '0;
        end else begin
            fill_valid_q <= 1'b0;
            if (!busy_q) begin
                if (refill_valid_i) begin
                    busy_q      <= 1'b1;
                    req_valid_q <= 1'b1;
                    word_cnt_q  <= '0;
                end
            end else if (req_valid_q) begin
                if (iomem_ready_i) begin
                    req_valid_q <= 1'b0;
                    if (word_cnt_q == l1i_pkg::offset_t'(l1i_pkg::WORDS_PER_LINE - 1)) begin
                        busy_q       <= 1'b0;
                        fill_valid_q <= 1'b1;
                    end else begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                    end
                end
            end else begin
                // Valid stays low for one cycle between words
                req_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && refill_valid_i) begin
            base_q <= refill_addr_i;
        end
        // Words arrive in order and shift in from the top so word 0 ends low
        if (req_valid_q && iomem_ready_i) begin
            line_q <= {iomem_rdata_i, line_q[l1i_pkg::LINE_BITS-1:l1i_pkg::WORD_BITS]};
        end
    end

    assign refill_ready_o = !busy_q;
    assign fill_valid_o   = fill_valid_q;
    assign fill_line_o    = line_q;

    assign iomem_valid_o     = req_valid_q;
    assign iomem_req_o.addr  = base_q + (l1i_pkg::addr_t'(word_cnt_q) << 2);
    assign iomem_req_o.wdata = '0;
    assign iomem_req_o.wstrb = '0;

endmodule

/* rtl/l1i_subsystem.sv */
`timescale 1ns/1ns

module l1i_subsystem (
    input  logic                clk,
    input  logic                resetn,
    input  logic                fetch_valid_i,
    input  l1i_pkg::addr_t      fetch_addr_i,
    output logic                fetch_ready_o,
    output logic                resp_valid_o,
    output l1i_pkg::word_t      resp_word_o,
    input  logic                resp_ready_i,
    output logic                iomem_valid_o,
    output l1i_pkg::mem_req_t   iomem_req_o,
    input  logic                iomem_ready_i,
    input  l1i_pkg::word_t      iomem_rdata_i
);

    logic                   rd_en;
    l1i_pkg::index_t        rd_index;
    l1i_pkg::tag_t          rd_tag;
    l1i_pkg::lookup_t       lookup;
    logic                   lookup_valid;
    logic                   wr_en;
    l1i_pkg::line_write_t   line_write;
    logic                   refill_valid;
    l1i_pkg::addr_t         refill_addr;
    logic                   refill_ready;
    logic                   fill_valid;
    l1i_pkg::line_t         fill_line;

    l1i_controller u_ctrl (
        .clk            (clk),
        .resetn         (resetn),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ready_o  (fetch_ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_word_o    (resp_word_o),
        .resp_ready_i   (resp_ready_i),
        .rd_en_o        (rd_en),
        .rd_index_o     (rd_index),
        .rd_tag_o       (rd_tag),
        .lookup_i       (lookup),
        .lookup_valid_i (lookup_valid),
        .wr_en_o        (wr_en),
        .line_write_o   (line_write),
        .refill_valid_o (refill_valid),
        .refill_addr_o  (refill_addr),
        .refill_ready_i (refill_ready),
        .fill_valid_i   (fill_valid),
        .fill_line_i    (fill_line)
    );

    l1i_way_store u_ways (
        .clk            (clk),
        .resetn         (resetn),
        .rd_en_i        (rd_en),
        .rd_index_i     (rd_index),
        .rd_tag_i       (rd_tag),
        .lookup_o       (lookup),
        .lookup_valid_o (lookup_valid),
        .wr_en_i        (wr_en),
        .line_write_i   (line_write)
    );

    mem_bus_bridge u_bridge (
        .clk            (clk),
        .resetn         (resetn),
        .refill_valid_i (refill_valid),
        .refill_addr_i  (refill_addr),
        .refill_ready_o (refill_ready),
        .fill_valid_o   (fill_valid),
        .fill_line_o    (fill_line),
        .iomem_valid_o  (iomem_valid_o),
        .iomem_req_o    (iomem_req_o),
        .iomem_ready_i  (iomem_ready_i),
        .iomem_rdata_i  (iomem_rdata_i)
    );

endmodule

/* test/tb_l1i_subsystem.sv */
`timescale 1ns/1ns

module tb_l1i_subsystem;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_VECTORS = 26;
    localparam int WAIT_POOL   = NUM_VECTORS * 4;
    localparam int WATCHDOG_NS = NUM_VECTORS * 40 * CLK_PERIOD;

    logic                clk = 1'b0;
    logic                resetn;
    logic                fetch_valid_i;
    l1i_pkg::addr_t      fetch_addr_i;
    logic                fetch_ready_o;
    logic                resp_valid_o;
    l1i_pkg::word_t      resp_word_o;
    logic                resp_ready_i;
    logic                iomem_valid_o;
    l1i_pkg::mem_req_t   iomem_req_o;
    logic                iomem_ready_i = 1'b0;
    l1i_pkg::word_t      iomem_rdata_i = '0;

    // Four words per vector for reset flag, address, expected word and hit flag
    logic [31:0]         vec_mem [NUM_VECTORS*4];
    int                  hold_cycles [NUM_VECTORS];
    int                  wait_pool [WAIT_POOL];
    logic [31:0]         lfsr_state = 32'h5bfc;

    l1i_pkg::addr_t      bus_addrs [$];
    int                  bus_valid_cycles = 0;
    int                  mem_word_idx = 0;
    int                  mem_wait_left = 0;
    logic                mem_waiting = 1'b0;

    l1i_subsystem UUT (
        .clk           (clk),
        .resetn        (resetn),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_ready_o (fetch_ready_o),
        .resp_valid_o  (resp_valid_o),
        .resp_word_o   (resp_word_o),
        .resp_ready_i  (resp_ready_i),
        .iomem_valid_o (iomem_valid_o),
        .iomem_req_o   (iomem_req_o),
        .iomem_ready_i (iomem_ready_i),
        .iomem_rdata_i (iomem_rdata_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    function automatic int take_bits(input int n);
        int value;
        value = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input l1i_pkg::word_t expected,
                              input l1i_pkg::word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error: %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_hit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error: %s hit: expected %b, actual %b",
                                     name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input l1i_pkg::addr_t expected,
                              input l1i_pkg::addr_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error: %s bus addr: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("** Error: %s: expected %0d, actual %0d",
                                     name, expected, actual));
        end
    endtask

    // Memory model answering each word with the inverse of its byte address
    always @(negedge clk) begin
        if (iomem_ready_i) begin
            iomem_ready_i = 1'b0;
        end else if (iomem_valid_o) begin
            bus_valid_cycles++;
            if (!mem_waiting) begin
                mem_waiting   = 1'b1;
                mem_wait_left = wait_pool[mem_word_idx % WAIT_POOL];
                mem_word_idx++;
            end
            if (mem_wait_left == 0) begin
                if (iomem_req_o.wstrb != '0) begin
                    report_failure("memory bus request arrived with a nonzero write strobe");
                end
                iomem_ready_i = 1'b1;
                iomem_rdata_i = ~iomem_req_o.addr;
                bus_addrs.push_back(iomem_req_o.addr);
                mem_waiting   = 1'b0;
            end else begin
                mem_wait_left--;
            end
        end
    end

    task automatic apply_reset();
        resetn = 1'b0;
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        if (!fetch_ready_o || resp_valid_o || iomem_valid_o) begin
            report_failure("outputs not in their idle state after reset");
        end
    endtask

    task automatic run_fetch(input int idx, input l1i_pkg::addr_t addr,
                             input l1i_pkg::word_t exp_word, input logic exp_hit);
        string          name;
        int             lat;
        int             cycles_before;
        int             reads_before;
        l1i_pkg::addr_t base;
        l1i_pkg::word_t held;
        name = $sformatf("vector %0d addr %h", idx, addr);
        base = addr & ~32'hF;
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addr;
        while (!fetch_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        fetch_valid_i = 1'b0;
        cycles_before = bus_valid_cycles;
        reads_before  = bus_addrs.size();
        lat = 0;
        while (!resp_valid_o) begin
            @(negedge clk);
            lat++;
        end
        check_word(name, exp_word, resp_word_o);
        check_hit(name, exp_hit, bus_valid_cycles == cycles_before);
        if (exp_hit) begin
            check_count({name, " hit latency"}, 2, lat);
        end else begin
            check_count({name, " bus reads"}, 4, bus_addrs.size() - reads_before);
            for (int k = 0; k < 4; k++) begin
                check_addr(name, base + l1i_pkg::addr_t'(4 * k), bus_addrs[reads_before + k]);
            end
        end
        // Response back-pressure
        held = resp_word_o;
        repeat (hold_cycles[idx]) begin
            @(negedge clk);
            if (!resp_valid_o) begin
                report_failure($sformatf("%s: response dropped while stalled", name));
            end
            if (fetch_ready_o) begin
                report_failure($sformatf("%s: fetch accepted while response pending", name));
            end
            check_word({name, " held"}, held, resp_word_o);
        end
        resp_ready_i = 1'b1;
        @(negedge clk);
        resp_ready_i = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog timeout, the fetch sequence did not finish in time");
    end

    initial begin
        resetn        = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        resp_ready_i  = 1'b0;
        $readmemh("test/fetch_vectors.txt", vec_mem);
        for (int i = 0; i < WAIT_POOL; i++) begin
            wait_pool[i] = take_bits(2);
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            hold_cycles[i] = take_bits(3);
        end
        apply_reset();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (vec_mem[4*i] != 0) begin
                apply_reset();
            end
            run_fetch(i, vec_mem[4*i+1], vec_mem[4*i+2], vec_mem[4*i+3][0]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* test/fetch_vectors.txt */
// reset_before  address  expected_word  expected_hit
// Cold miss, then hits in the same line
0 00001000 FFFFEFFF 0
0 0000100C FFFFEFF3 1
0 00001004 FFFFEFFB 1
// Set 5, two tags resident
0 00002050 FFFFDFAF 0
0 00003058 FFFFCFA7 0
0 0000205C FFFFDFA3 1
0 00003054 FFFFCFAB 1
// Third tag evicts by the victim bit
0 00004050 FFFFBFAF 0
0 00003050 FFFFCFAF 1
0 00002054 FFFFDFAB 0
0 00004058 FFFFBFA7 1
0 00002050 FFFFDFAF 1
0 00003050 FFFFCFAF 0
0 0000205C FFFFDFA3 1
0 00004050 FFFFBFAF 0
0 00003058 FFFFCFA7 1
0 00002050 FFFFDFAF 0
// Other sets
0 ABCD1230 5432EDCF 0
0 ABCD123C 5432EDC3 1
0 00001018 FFFFEFE7 0
0 00001008 FFFFEFF7 1
// Second reset clears every line
1 00001008 FFFFEFF7 0
0 0000205C FFFFDFA3 0
0 ABCD1234 5432EDCB 0
0 00001000 FFFFEFFF 1
0 00004054 FFFFBFAB 0

/* compile.f */
rtl/l1i_pkg.sv
rtl/l1i_controller.sv
rtl/l1i_way_store.sv
rtl/mem_bus_bridge.sv
rtl/l1i_subsystem.sv
test/tb_l1i_subsystem.sv

/* Makefile */
# Verilator flow for the L1 instruction cache subsystem

VERILATOR ?= verilator
TOP       ?= tb_l1i_subsystem
LINT_TOP  ?= l1i_subsystem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
